//--- design/l15_pkg.sv
package l15_pkg;

	// Owner of the shared L1.5 port
	// Fetch owns it out of reset
	typedef enum logic [1:0]
	{
		arb_instr = 2'd0,
		// Memory op waiting for the fetch response to drain
		arb_wait  = 2'd1,
		// Data memory holds the port
		arb_mem   = 2'd2
	} arb_state_t;

	// Request type toward the L1.5
	typedef logic [4:0] rqtype_t;

	// Request size code
	typedef logic [2:0] size_t;

	// Return type of a response
	// Four bits on both sides of the port
	typedef logic [3:0] rtype_t;

endpackage

//--- design/l15_arb_fsm.sv
`timescale 1ns/1ps

module l15_arb_fsm
(
	input  logic                clk,
	input  logic                nrst,

	// Memory side status
	input  logic                mem_pending,
	input  logic                mem_done,

	// Fetch side status
	input  logic                fetch_waiting,

	// Response valid straight from the cache
	input  logic                cache_resp_val,

	output l15_pkg::arb_state_t arb_state,
	output logic                stall_mem,
	output logic                mem_granted
);

	import l15_pkg::*;

	arb_state_t state_next;
	logic       fetch_drained;
	logic       mem_release;

	// Nothing outstanding on fetch, or its response is here now
	assign fetch_drained = !fetch_waiting || (fetch_waiting && cache_resp_val);

	// Last memory op finished with nothing behind it
	assign mem_release = mem_done && !mem_pending;

	// Next owner of the port
	always_comb
	begin
		state_next = arb_state;
		case (arb_state)
			arb_instr:
			begin
				// Memory op shows up
				if (mem_pending)
				begin
					state_next = arb_wait;
				end
			end
			arb_wait:
			begin
				// Hand over once fetch has nothing in flight
				if (fetch_drained)
				begin
					state_next = arb_mem;
				end
			end
			arb_mem:
			begin
				if (mem_release)
				begin
					state_next = arb_instr;
				end
			end
			default:
			begin
				// Unused encoding falls back to fetch
				state_next = arb_instr;
			end
		endcase
	end

	// State and the two flags move on the same edge
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			arb_state   <= arb_instr;
			stall_mem   <= 1'b0;
			mem_granted <= 1'b0;
		end
		else
		begin
			arb_state   <= state_next;
			// High for the whole wait state
			stall_mem   <= (state_next == arb_wait);
			// High for the whole memory state
			mem_granted <= (state_next == arb_mem);
		end
	end

endmodule

//--- design/l15_port_mux.sv
`timescale 1ns/1ps

module l15_port_mux
#(
	parameter int addr_width = 32,
	parameter int data_width = 64
)
(
	input  l15_pkg::arb_state_t   arb_state,

	// Fetch side
	input  l15_pkg::rqtype_t      fetch_rqtype,
	input  l15_pkg::size_t        fetch_size,
	input  logic [addr_width-1:0] fetch_address,
	input  logic [data_width-1:0] fetch_data,
	input  logic                  fetch_val,
	input  logic                  fetch_req_ack,
	output logic                  fetch_ack,
	output logic                  fetch_header_ack,
	output logic                  fetch_resp_val,
	output logic [data_width-1:0] fetch_resp_data_0,
	output logic [data_width-1:0] fetch_resp_data_1,
	output l15_pkg::rtype_t       fetch_returntype,

	// Data memory side
	input  l15_pkg::rqtype_t      mem_rqtype,
	input  l15_pkg::size_t        mem_size,
	input  logic [addr_width-1:0] mem_address,
	input  logic [data_width-1:0] mem_data,
	input  logic                  mem_val,
	input  logic                  mem_req_ack,
	output logic                  mem_ack,
	output logic                  mem_header_ack,
	output logic                  mem_resp_val,
	output logic [data_width-1:0] mem_resp_data_0,
	output logic [data_width-1:0] mem_resp_data_1,
	output l15_pkg::rtype_t       mem_returntype,

	// Cache side
	output l15_pkg::rqtype_t      cache_rqtype,
	output l15_pkg::size_t        cache_size,
	output logic [addr_width-1:0] cache_address,
	output logic [data_width-1:0] cache_data,
	output logic                  cache_val,
	output logic                  cache_req_ack,
	input  logic                  cache_ack,
	input  logic                  cache_header_ack,
	input  logic                  cache_resp_val,
	input  logic [data_width-1:0] cache_resp_data_0,
	input  logic [data_width-1:0] cache_resp_data_1,
	input  l15_pkg::rtype_t       cache_returntype
);

	import l15_pkg::*;

	// Response payload goes to both sides as is
	// Only the valids and acks say who it belongs to
	assign fetch_resp_data_0 = cache_resp_data_0;
	assign fetch_resp_data_1 = cache_resp_data_1;
	assign fetch_returntype  = cache_returntype;
	assign mem_resp_data_0   = cache_resp_data_0;
	assign mem_resp_data_1   = cache_resp_data_1;
	assign mem_returntype    = cache_returntype;

	always_comb
	begin
		// Request fields follow fetch unless memory owns the port
		cache_rqtype     = fetch_rqtype;
		cache_size       = fetch_size;
		cache_address    = fetch_address;
		cache_data       = fetch_data;
		cache_val        = 1'b0;
		cache_req_ack    = 1'b0;
		// Neither side hears anything by default
		fetch_ack        = 1'b0;
		fetch_header_ack = 1'b0;
		fetch_resp_val   = 1'b0;
		mem_ack          = 1'b0;
		mem_header_ack   = 1'b0;
		mem_resp_val     = 1'b0;
		case (arb_state)
			arb_instr:
			begin
				// Fetch talks straight to the cache
				cache_val        = fetch_val;
				cache_req_ack    = fetch_req_ack;
				fetch_ack        = cache_ack;
				fetch_header_ack = cache_header_ack;
				fetch_resp_val   = cache_resp_val;
			end
			arb_wait:
			begin
				// No new request accepted from either side
				// In-flight fetch response still drains to fetch
				cache_req_ack  = fetch_req_ack;
				fetch_ack      = cache_ack;
				fetch_resp_val = cache_resp_val;
			end
			arb_mem:
			begin
				cache_rqtype   = mem_rqtype;
				cache_size     = mem_size;
				cache_address  = mem_address;
				cache_data     = mem_data;
				cache_val      = mem_val;
				cache_req_ack  = mem_req_ack;
				mem_ack        = cache_ack;
				mem_header_ack = cache_header_ack;
				mem_resp_val   = cache_resp_val;
			end
			default:
			begin
				// Port parked, defaults hold
				cache_val = 1'b0;
			end
		endcase
	end

endmodule

//--- design/l15_port_share.sv
`timescale 1ns/1ps

module l15_port_share
#(
	parameter int addr_width = 32,
	parameter int data_width = 64
)
(
	input  logic                  clk,
	input  logic                  nrst,

	// Arbitration status and flags
	input  logic                  mem_pending,
	input  logic                  mem_done,
	input  logic                  fetch_waiting,
	output logic                  stall_mem,
	output logic                  mem_granted,

	// Fetch side
	input  l15_pkg::rqtype_t      fetch_rqtype,
	input  l15_pkg::size_t        fetch_size,
	input  logic [addr_width-1:0] fetch_address,
	input  logic [data_width-1:0] fetch_data,
	input  logic                  fetch_val,
	input  logic                  fetch_req_ack,
	output logic                  fetch_ack,
	output logic                  fetch_header_ack,
	output logic                  fetch_resp_val,
	output logic [data_width-1:0] fetch_resp_data_0,
	output logic [data_width-1:0] fetch_resp_data_1,
	output l15_pkg::rtype_t       fetch_returntype,

	// Data memory side
	input  l15_pkg::rqtype_t      mem_rqtype,
	input  l15_pkg::size_t        mem_size,
	input  logic [addr_width-1:0] mem_address,
	input  logic [data_width-1:0] mem_data,
	input  logic                  mem_val,
	input  logic                  mem_req_ack,
	output logic                  mem_ack,
	output logic                  mem_header_ack,
	output logic                  mem_resp_val,
	output logic [data_width-1:0] mem_resp_data_0,
	output logic [data_width-1:0] mem_resp_data_1,
	output l15_pkg::rtype_t       mem_returntype,

	// Single L1.5 port
	output l15_pkg::rqtype_t      cache_rqtype,
	output l15_pkg::size_t        cache_size,
	output logic [addr_width-1:0] cache_address,
	output logic [data_width-1:0] cache_data,
	output logic                  cache_val,
	output logic                  cache_req_ack,
	input  logic                  cache_ack,
	input  logic                  cache_header_ack,
	input  logic                  cache_resp_val,
	input  logic [data_width-1:0] cache_resp_data_0,
	input  logic [data_width-1:0] cache_resp_data_1,
	input  l15_pkg::rtype_t       cache_returntype
);

	import l15_pkg::*;

	// Current owner, decided only by the FSM
	arb_state_t arb_state;

	l15_arb_fsm i_arb_fsm
	(
		.clk            (clk),
		.nrst           (nrst),
		.mem_pending    (mem_pending),
		.mem_done       (mem_done),
		.fetch_waiting  (fetch_waiting),
		.cache_resp_val (cache_resp_val),
		.arb_state      (arb_state),
		.stall_mem      (stall_mem),
		.mem_granted    (mem_granted)
	);

	l15_port_mux
	#(
		.addr_width (addr_width),
		.data_width (data_width)
	)
	i_port_mux
	(
		.arb_state         (arb_state),
		.fetch_rqtype      (fetch_rqtype),
		.fetch_size        (fetch_size),
		.fetch_address     (fetch_address),
		.fetch_data        (fetch_data),
		.fetch_val         (fetch_val),
		.fetch_req_ack     (fetch_req_ack),
		.fetch_ack         (fetch_ack),
		.fetch_header_ack  (fetch_header_ack),
		.fetch_resp_val    (fetch_resp_val),
		.fetch_resp_data_0 (fetch_resp_data_0),
		.fetch_resp_data_1 (fetch_resp_data_1),
		.fetch_returntype  (fetch_returntype),
		.mem_rqtype        (mem_rqtype),
		.mem_size          (mem_size),
		.mem_address       (mem_address),
		.mem_data          (mem_data),
		.mem_val           (mem_val),
		.mem_req_ack       (mem_req_ack),
		.mem_ack           (mem_ack),
		.mem_header_ack    (mem_header_ack),
		.mem_resp_val      (mem_resp_val),
		.mem_resp_data_0   (mem_resp_data_0),
		.mem_resp_data_1   (mem_resp_data_1),
		.mem_returntype    (mem_returntype),
		.cache_rqtype      (cache_rqtype),
		.cache_size        (cache_size),
		.cache_address     (cache_address),
		.cache_data        (cache_data),
		.cache_val         (cache_val),
		.cache_req_ack     (cache_req_ack),
		.cache_ack         (cache_ack),
		.cache_header_ack  (cache_header_ack),
		.cache_resp_val    (cache_resp_val),
		.cache_resp_data_0 (cache_resp_data_0),
		.cache_resp_data_1 (cache_resp_data_1),
		.cache_returntype  (cache_returntype)
	);

endmodule

//--- verification/l15_port_share_checks.svh
`ifndef L15_PORT_SHARE_CHECKS_SVH
`define L15_PORT_SHARE_CHECKS_SVH

// Expected cache request plus {ack, header_ack, resp_val} toward each side
typedef struct packed
{
	rqtype_t               rqtype;
	size_t                 size;
	logic [addr_width-1:0] address;
	logic [data_width-1:0] data;
	logic                  val;
	logic                  req_ack;
	logic [2:0]            to_fetch;
	logic [2:0]            to_mem;
} steer_t;

// Port owner after one clock edge
function automatic arb_state_t next_state(input arb_state_t st, input logic pending,
	input logic done, input logic waiting, input logic resp);
	case (st)
		arb_instr: return pending ? arb_wait : arb_instr;
		// Moves on at once when no fetch response is outstanding
		arb_wait:  return (!waiting || resp) ? arb_mem : arb_wait;
		arb_mem:   return (done && !pending) ? arb_instr : arb_mem;
		default:   return arb_instr;
	endcase
endfunction

// Steered outputs for an owner and the inputs driven right now
function automatic steer_t expected_steer(input arb_state_t st);
	steer_t     s;
	logic [2:0] from_cache;
	from_cache = {cache_ack, cache_header_ack, cache_resp_val};
	// Fetch talks to the cache, memory hears nothing
	s = {fetch_rqtype, fetch_size, fetch_address, fetch_data, fetch_val, fetch_req_ack,
		from_cache, 3'b000};
	if (st == arb_wait)
	begin
		// No new request and no header ack
		s.val         = 1'b0;
		s.to_fetch[1] = 1'b0;
	end
	else if (st == arb_mem)
		s = {mem_rqtype, mem_size, mem_address, mem_data, mem_val, mem_req_ack,
			3'b000, from_cache};
	return s;
endfunction

// Kind 0 flags, 1 request fields, 2 data words
task automatic note_error(input logic [1:0] kind, input string msg);
	$display("Error: %s", msg);
	error_count[kind]++;
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
		note_error(2'd0, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

task automatic check_rqtype(input string name, input rqtype_t exp, input rqtype_t act);
	if (act !== exp)
		note_error(2'd1, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

task automatic check_size(input string name, input size_t exp, input size_t act);
	if (act !== exp)
		note_error(2'd1, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

task automatic check_rtype(input string name, input rtype_t exp, input rtype_t act);
	if (act !== exp)
		note_error(2'd1, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

task automatic check_addr(input string name, input logic [addr_width-1:0] exp,
	input logic [addr_width-1:0] act);
	if (act !== exp)
		note_error(2'd1, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

task automatic check_word(input string name, input logic [data_width-1:0] exp,
	input logic [data_width-1:0] act);
	if (act !== exp)
		note_error(2'd2, $sformatf("%s expected %h, got %h", name, exp, act));
endtask

// Every DUT output against the model for the current cycle
task automatic compare_outputs();
	steer_t exp;
	exp = expected_steer(model_state);
	check_flag("stall_mem", model_state == arb_wait, stall_mem);
	check_flag("mem_granted", model_state == arb_mem, mem_granted);
	check_rqtype("cache_rqtype", exp.rqtype, cache_rqtype);
	check_size("cache_size", exp.size, cache_size);
	check_addr("cache_address", exp.address, cache_address);
	check_word("cache_data", exp.data, cache_data);
	check_flag("cache_val", exp.val, cache_val);
	check_flag("cache_req_ack", exp.req_ack, cache_req_ack);
	check_flag("fetch_ack", exp.to_fetch[2], fetch_ack);
	check_flag("fetch_header_ack", exp.to_fetch[1], fetch_header_ack);
	check_flag("fetch_resp_val", exp.to_fetch[0], fetch_resp_val);
	check_flag("mem_ack", exp.to_mem[2], mem_ack);
	check_flag("mem_header_ack", exp.to_mem[1], mem_header_ack);
	check_flag("mem_resp_val", exp.to_mem[0], mem_resp_val);
	// Payload reaches both sides untouched
	check_word("fetch_resp_data_0", cache_resp_data_0, fetch_resp_data_0);
	check_word("fetch_resp_data_1", cache_resp_data_1, fetch_resp_data_1);
	check_word("mem_resp_data_0", cache_resp_data_0, mem_resp_data_0);
	check_word("mem_resp_data_1", cache_resp_data_1, mem_resp_data_1);
	check_rtype("fetch_returntype", cache_returntype, fetch_returntype);
	check_rtype("mem_returntype", cache_returntype, mem_returntype);
endtask

`endif

//--- verification/l15_port_share_tb.sv
`timescale 1ns/1ps

module l15_port_share_tb;

	import l15_pkg::*;

	localparam int addr_width      = 32;
	localparam int data_width      = 64;
	localparam int directed_cycles = 150;
	localparam int random_cycles   = 2000;
	// Both test parts plus room for the bounded waits
	localparam int timeout_cycles  = directed_cycles + random_cycles + 850;
	localparam int wait_limit      = 16;

	logic clk;
	logic nrst;
	logic mem_pending, mem_done, fetch_waiting;
	logic stall_mem, mem_granted;
	logic fetch_val, fetch_req_ack, fetch_ack, fetch_header_ack, fetch_resp_val;
	logic mem_val, mem_req_ack, mem_ack, mem_header_ack, mem_resp_val;
	logic cache_val, cache_req_ack, cache_ack, cache_header_ack, cache_resp_val;
	rqtype_t fetch_rqtype, mem_rqtype, cache_rqtype;
	size_t fetch_size, mem_size, cache_size;
	rtype_t fetch_returntype, mem_returntype, cache_returntype;
	logic [addr_width-1:0] fetch_address, mem_address, cache_address;
	logic [data_width-1:0] fetch_data, mem_data, cache_data;
	logic [data_width-1:0] cache_resp_data_0, cache_resp_data_1;
	logic [data_width-1:0] fetch_resp_data_0, fetch_resp_data_1;
	logic [data_width-1:0] mem_resp_data_0, mem_resp_data_1;
	arb_state_t model_state = arb_instr;
	// Flags, request fields, data words, waits
	int error_count [4] = '{default: 0};
	int cycle_count = 0;

	`include "l15_port_share_checks.svh"

	l15_port_share i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Request fields, cache acks and payload, all random
	task automatic drive_payload();
		fetch_rqtype      <= 5'($urandom);
		fetch_size        <= 3'($urandom);
		fetch_address     <= $urandom;
		fetch_data        <= {$urandom, $urandom};
		fetch_val         <= 1'($urandom);
		fetch_req_ack     <= 1'($urandom);
		mem_rqtype        <= 5'($urandom);
		mem_size          <= 3'($urandom);
		mem_address       <= $urandom;
		mem_data          <= {$urandom, $urandom};
		mem_val           <= 1'($urandom);
		mem_req_ack       <= 1'($urandom);
		cache_ack         <= 1'($urandom);
		cache_header_ack  <= 1'($urandom);
		cache_resp_data_0 <= {$urandom, $urandom};
		cache_resp_data_1 <= {$urandom, $urandom};
		cache_returntype  <= 4'($urandom);
	endtask

	// One edge, control bits are {pending, done, waiting, resp}
	task automatic step(input logic [3:0] ctrl);
		@(posedge clk);
		drive_payload();
		mem_pending    <= ctrl[3];
		mem_done       <= ctrl[2];
		fetch_waiting  <= ctrl[1];
		cache_resp_val <= ctrl[0];
	endtask

	// Holds the controls until mem_granted reaches the wanted level
	task automatic wait_grant(input logic level, input logic [3:0] ctrl);
		int n;
		n = 0;
		do
		begin
			step(ctrl);
			#1;
			n++;
		end
		while (mem_granted !== level && n < wait_limit);
		if (mem_granted !== level)
		begin
			$display("mem_granted never went to %0b within %0d cycles", level, wait_limit);
			error_count[3]++;
		end
	endtask

	task automatic print_counts();
		$display("Errors: flags %0d, request fields %0d, data %0d, waits %0d",
			error_count[0], error_count[1], error_count[2], error_count[3]);
	endtask

	// Model advances on the values sampled at the edge
	always @(posedge clk)
	begin
		if (!nrst)
			model_state = arb_instr;
		else
			model_state = next_state(model_state, mem_pending, mem_done, fetch_waiting,
				cache_resp_val);
		cycle_count++;
		// Outputs settled
		#1;
		compare_outputs();
		if (cycle_count >= timeout_cycles)
		begin
			$display("Run hit the %0d cycle limit before finishing", timeout_cycles);
			print_counts();
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'h80ef694f));
		nrst = 1'b0;
		drive_payload();
		mem_pending    <= 1'b0;
		mem_done       <= 1'b0;
		fetch_waiting  <= 1'b0;
		cache_resp_val <= 1'b0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		// Fetch alone on the port
		repeat (8) step(4'b0000);
		// Nothing in flight on fetch, handover right after the stall cycle
		step(4'b1000);
		wait_grant(1'b1, 4'b0000);
		repeat (4) step(4'b0000);
		// Done with more memory work queued keeps the grant
		step(4'b1100);
		repeat (2) step(4'b0000);
		wait_grant(1'b0, 4'b0100);
		// Fetch response outstanding, stall until it shows up
		step(4'b1010);
		repeat (5) step(4'b0010);
		step(4'b0011);
		wait_grant(1'b1, 4'b0010);
		repeat (4) step(4'b0000);
		wait_grant(1'b0, 4'b0100);
		// Everything random
		repeat (random_cycles) step(4'($urandom));
		@(posedge clk);
		#2;
		print_counts();
		if (error_count[0] + error_count[1] + error_count[2] + error_count[3] == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verification
design/l15_pkg.sv
design/l15_arb_fsm.sv
design/l15_port_mux.sv
design/l15_port_share.sv
verification/l15_port_share_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the L1.5 port sharing testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --timescale 1ns/1ps --top-module l15_port_share_tb \
	-f filelist.f -o l15_port_share_sim
then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/l15_port_share_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]
then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"
then
	exit 0
fi
exit 1
